//--- iba_pkg.sv
package iba_pkg;

   // buffer RAM geometry
   localparam int DATA_W    = 32;
   localparam int ADDR_W    = 8;
   localparam int RAM_DEPTH = 256;   // 2**ADDR_W words

   // upper part of frame word 2 that goes into the second header word
   localparam int MAC_HI_W = 16;

   typedef logic [DATA_W-1:0] word_t;   // one frame word
   typedef logic [ADDR_W-1:0] addr_t;   // buffer address, wraps at RAM_DEPTH

endpackage

//--- dpq_pkg.sv
package dpq_pkg;

   // word count of a frame or a read request
   localparam int LEN_W = 8;

   typedef logic [LEN_W-1:0] len_t;

   // read controller states
   typedef enum logic [1:0]
   {
      IDLE,    // waiting for a request
      READ,    // issuing reads, stalled by writes
      DRAIN    // last read issued, word still in flight
   } rd_state_e;

endpackage

//--- ram_if.sv
interface ram_if
   import iba_pkg::*;
();

   logic  we;      // write strobe
   addr_t waddr;
   word_t wdata;
   logic  re;      // read strobe, data one cycle later
   addr_t raddr;
   word_t rdata;

   modport writer (output we, output waddr, output wdata);

   modport reader (output re, output raddr, input rdata);

   modport mem
   (
      input  we, input waddr, input wdata,
      input  re, input raddr,
      output rdata
   );

endinterface

//--- frame_ram.sv
module frame_ram
   import iba_pkg::*;
(
   input logic clk,
   ram_if.mem  ram
);

   word_t mem_q [RAM_DEPTH];

   // synchronous write port
   always_ff @(posedge clk)
   begin
      if (ram.we)
      begin
         mem_q[ram.waddr] <= ram.wdata;
      end
   end

   // registered read, rdata is held between reads
   always_ff @(posedge clk)
   begin
      if (ram.re)
      begin
         ram.rdata <= mem_q[ram.raddr];
      end
   end

   // the controller never reads and writes in the same cycle,
   // so no read-during-write behaviour is needed here

endmodule

//--- frame_writer.sv
module frame_writer
   import iba_pkg::*, dpq_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n_i,
   input  logic  wr_valid_i,
   input  logic  sof_i,
   input  logic  eof_i,
   input  word_t wr_data_i,
   ram_if.writer ram,
   output logic  hdr_valid_o,
   output word_t hdr_data_o
);

   addr_t               wr_ptr_q;       // next free buffer word
   addr_t               start_addr_q;   // address of the current frame's first word
   len_t                len_cnt_q;      // words of the current frame so far
   len_t                frame_len_d;
   word_t               first_word_q;
   word_t               hdr_word1_q;
   word_t               hdr_data_q;
   logic [MAC_HI_W-1:0] mac_hi_q;
   logic [MAC_HI_W-1:0] mac_hi_d;
   logic                hdr_first_q;
   logic                hdr_second_q;
   logic                wr_sof;
   logic                wr_eof;

   assign wr_sof = wr_valid_i & sof_i;
   assign wr_eof = wr_valid_i & eof_i;

   // length including the word on the bus
   assign frame_len_d = len_cnt_q + 1'b1;

   // second word of the frame carries the upper dmac bits
   assign mac_hi_d = (len_cnt_q == LEN_W'(1)) ? wr_data_i[DATA_W-1 -: MAC_HI_W] : mac_hi_q;

   // RAM write port, written in the same cycle as the word arrives
   assign ram.we    = wr_valid_i;
   assign ram.waddr = wr_ptr_q;
   assign ram.wdata = wr_data_i;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q     <= '0;
         len_cnt_q    <= '0;
         hdr_first_q  <= 1'b0;
         hdr_second_q <= 1'b0;
      end
      else
      begin
         if (wr_valid_i)
         begin
            wr_ptr_q  <= wr_ptr_q + 1'b1;   // wraps at 256
            len_cnt_q <= sof_i ? LEN_W'(1) : frame_len_d;
         end
         hdr_first_q  <= wr_eof;
         hdr_second_q <= hdr_first_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_sof)
      begin
         start_addr_q <= wr_ptr_q;
         first_word_q <= wr_data_i;
      end
      if (wr_valid_i && !sof_i)
      begin
         mac_hi_q <= mac_hi_d;
      end
      // both header words are frozen at eof, so a following sof
      // cannot disturb them
      if (wr_eof)
      begin
         hdr_data_q  <= first_word_q;
         hdr_word1_q <= {mac_hi_d, frame_len_d, start_addr_q};
      end
      else if (hdr_first_q)
      begin
         hdr_data_q <= hdr_word1_q;
      end
   end

   assign hdr_valid_o = hdr_first_q | hdr_second_q;
   assign hdr_data_o  = hdr_data_q;

endmodule

//--- read_sequencer.sv
module read_sequencer
   import iba_pkg::*, dpq_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n_i,
   input  logic  load_i,     // take start_i and len_i
   input  logic  step_i,     // issue one read
   input  addr_t start_i,
   input  len_t  len_i,
   ram_if.reader ram,
   output logic  last_o,
   output logic  rd_valid_o,
   output word_t rd_data_o
);

   addr_t rd_addr_q;
   len_t  remain_q;     // reads still to issue
   logic  rd_valid_q;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rd_addr_q  <= '0;
         remain_q   <= '0;
         rd_valid_q <= 1'b0;
      end
      else
      begin
         if (load_i)
         begin
            rd_addr_q <= start_i;
            remain_q  <= len_i;
         end
         else if (step_i)
         begin
            rd_addr_q <= rd_addr_q + 1'b1;   // wraps past 255
            remain_q  <= remain_q - 1'b1;
         end
         rd_valid_q <= step_i;   // lines up with registered RAM data
      end
   end

   assign ram.re    = step_i;
   assign ram.raddr = rd_addr_q;

   // this step issues the final read
   assign last_o = step_i && (remain_q == LEN_W'(1));

   assign rd_valid_o = rd_valid_q;
   assign rd_data_o  = ram.rdata;

endmodule

//--- iba_ctrl.sv
module iba_ctrl
   import dpq_pkg::*;
(
   input  logic clk,
   input  logic rst_n_i,
   input  logic req_valid_i,
   input  logic wr_valid_i,   // a write owns the RAM this cycle
   input  logic last_i,
   output logic req_ready_o,
   output logic load_o,
   output logic step_o,
   output logic done_o
);

   rd_state_e state_q;
   rd_state_e state_d;
   logic      done_q;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (load_o)
            begin
               state_d = READ;
            end
         end
         READ:
         begin
            if (last_i)
            begin
               state_d = DRAIN;
            end
         end
         DRAIN:
         begin
            state_d = IDLE;   // final word leaves the RAM now
         end
         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q <= IDLE;
         done_q  <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         done_q  <= (state_q == DRAIN);   // cycle after the last rd_valid
      end
   end

   // a new request is taken only once done has been seen
   assign req_ready_o = (state_q == IDLE) && !done_q;
   assign load_o      = req_ready_o && req_valid_i;
   assign step_o      = (state_q == READ) && !wr_valid_i;   // writes win
   assign done_o      = done_q;

endmodule

//--- iba_buffer_top.sv
module iba_buffer_top
   import iba_pkg::*, dpq_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n_i,
   // frame write side
   input  logic  wr_valid_i,
   input  logic  sof_i,
   input  logic  eof_i,
   input  word_t wr_data_i,
   // queue manager requests
   input  logic  req_valid_i,
   input  addr_t req_start_i,
   input  len_t  req_len_i,
   output logic  req_ready_o,
   // header to the descriptor unit
   output logic  hdr_valid_o,
   output word_t hdr_data_o,
   // read-out
   output logic  rd_valid_o,
   output word_t rd_data_o,
   output logic  done_o
);

   logic load;
   logic step;
   logic last;

   ram_if i_ram_if ();

   frame_ram i_frame_ram
   (
      .clk (clk),
      .ram (i_ram_if.mem)
   );

   frame_writer i_frame_writer
   (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .wr_valid_i  (wr_valid_i),
      .sof_i       (sof_i),
      .eof_i       (eof_i),
      .wr_data_i   (wr_data_i),
      .ram         (i_ram_if.writer),
      .hdr_valid_o (hdr_valid_o),
      .hdr_data_o  (hdr_data_o)
   );

   read_sequencer i_read_sequencer
   (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .load_i     (load),
      .step_i     (step),
      .start_i    (req_start_i),
      .len_i      (req_len_i),
      .ram        (i_ram_if.reader),
      .last_o     (last),
      .rd_valid_o (rd_valid_o),
      .rd_data_o  (rd_data_o)
   );

   iba_ctrl i_iba_ctrl
   (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .req_valid_i (req_valid_i),
      .wr_valid_i  (wr_valid_i),
      .last_i      (last),
      .req_ready_o (req_ready_o),
      .load_o      (load),
      .step_o      (step),
      .done_o      (done_o)
   );

endmodule

//--- tb_iba_buffer.sv
module tb_iba_buffer
   import iba_pkg::*, dpq_pkg::*;
();

   // summed worst case cycles of reset, headers, read-back, write priority and busy requests
   localparam int TEST_CYCLES  = 20 + 5 * 24 + (262 + 2 * 46) + (60 + 3 * 34 + 10) + 60;
   localparam int LIMIT_CYCLES = TEST_CYCLES + 200;

   logic  clk;
   logic  rst_n_i;
   logic  wr_valid_i;
   logic  sof_i;
   logic  eof_i;
   word_t wr_data_i;
   logic  req_valid_i;
   addr_t req_start_i;
   len_t  req_len_i;
   logic  req_ready_o;
   logic  hdr_valid_o;
   word_t hdr_data_o;
   logic  rd_valid_o;
   word_t rd_data_o;
   logic  done_o;

   word_t model_mem [RAM_DEPTH];   // expected buffer contents
   addr_t model_ptr;
   int    error_count;
   int    test_errors;
   int    test_count;
   int    accept_count;
   string test_name;

   iba_buffer_top i_iba_buffer_top
   (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .wr_valid_i  (wr_valid_i),
      .sof_i       (sof_i),
      .eof_i       (eof_i),
      .wr_data_i   (wr_data_i),
      .req_valid_i (req_valid_i),
      .req_start_i (req_start_i),
      .req_len_i   (req_len_i),
      .req_ready_o (req_ready_o),
      .hdr_valid_o (hdr_valid_o),
      .hdr_data_o  (hdr_data_o),
      .rd_valid_o  (rd_valid_o),
      .rd_data_o   (rd_data_o),
      .done_o      (done_o)
   );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      if (req_valid_i && req_ready_o)
      begin
         accept_count++;
      end
   end

   // no request is taken while a transfer runs
   busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
      (i_iba_buffer_top.i_iba_ctrl.state_q != IDLE) |-> !req_ready_o)
   else
   begin
      $display("%s: req_ready_o high while a transfer is active", test_name);
      error_count++;
   end

   done_not_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
      done_o |-> !req_ready_o)
   else
   begin
      $display("%s: req_ready_o high together with done_o", test_name);
      error_count++;
   end

   // a write cycle issues no read, so no read word follows it
   write_stalls_read: assert property (@(posedge clk) disable iff (!rst_n_i)
      wr_valid_i |=> !rd_valid_o)
   else
   begin
      $display("%s: read word returned in the cycle after a write", test_name);
      error_count++;
   end

   task automatic check_word(input string what, input word_t exp, input word_t act);
      assert (exp === act)
      else
      begin
         $display("MISMATCH %s (%s) expected %h actual %h", test_name, what, exp, act);
         error_count++;
      end
   endtask

   task automatic check_flag(input logic ok, input string what);
      assert (ok)
      else
      begin
         $display("%s: %s", test_name, what);
         error_count++;
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = error_count;
   endtask

   task automatic end_test();
      test_count++;
      if (error_count == test_errors)
         $display("test %s: ok", test_name);
      else
         $display("test %s: failed with %0d errors", test_name, error_count - test_errors);
   endtask

   // writes one frame and checks both header words
   task automatic write_frame(input int len);
      word_t d;
      word_t first;
      word_t second;
      addr_t start;
      start  = model_ptr;
      first  = '0;
      second = '0;
      for (int i = 0; i < len; i++)
      begin
         d = $urandom;
         if (i == 0)
            first = d;
         if (i == 1)
            second = d;
         @(posedge clk);
         wr_valid_i <= 1'b1;
         sof_i      <= (i == 0);
         eof_i      <= (i == len - 1);
         wr_data_i  <= d;
         model_mem[model_ptr] = d;
         model_ptr = model_ptr + 1'b1;
      end
      @(posedge clk);
      wr_valid_i <= 1'b0;
      sof_i      <= 1'b0;
      eof_i      <= 1'b0;
      @(negedge clk);
      check_flag(hdr_valid_o, "first header cycle missing");
      check_word("header word 0", first, hdr_data_o);
      @(negedge clk);
      check_flag(hdr_valid_o, "second header cycle missing");
      check_word("header word 1", {second[31:16], len_t'(len), start}, hdr_data_o);
      @(negedge clk);
      check_flag(!hdr_valid_o, "header valid longer than two cycles");
   endtask

   task automatic request(input addr_t start, input int len);
      @(posedge clk);
      req_valid_i <= 1'b1;
      req_start_i <= start;
      req_len_i   <= len_t'(len);
      @(negedge clk);
      while (!req_ready_o)
         @(negedge clk);
      @(posedge clk);
      req_valid_i <= 1'b0;   // accepted on this edge
   endtask

   // collects read words until done and compares them with the model
   task automatic collect(input addr_t start, input int len);
      int   n;
      logic prev_valid;
      logic seen;
      addr_t idx;
      n          = 0;
      prev_valid = 1'b0;
      seen       = 1'b0;
      while (!seen)
      begin
         @(negedge clk);
         if (rd_valid_o)
         begin
            idx = start + addr_t'(n);
            check_flag(n < len, "more read words than requested");
            check_word($sformatf("read word %0d", n), model_mem[idx], rd_data_o);
            n++;
         end
         if (done_o)
         begin
            check_flag(prev_valid && !rd_valid_o, "done_o not in the cycle after the last word");
            check_flag(n == len, $sformatf("done after %0d of %0d words", n, len));
            seen = 1'b1;
         end
         prev_valid = rd_valid_o;
      end
      @(negedge clk);
      check_flag(!done_o, "done_o longer than one cycle");
   endtask

   initial
   begin
      int acc;
      void'($urandom(32'h77ff));
      clk          = 1'b0;
      rst_n_i      = 1'b0;
      wr_valid_i   = 1'b0;
      sof_i        = 1'b0;
      eof_i        = 1'b0;
      wr_data_i    = '0;
      req_valid_i  = 1'b0;
      req_start_i  = '0;
      req_len_i    = '0;
      model_ptr    = '0;
      error_count  = 0;
      test_count   = 0;
      accept_count = 0;
      test_name    = "reset";
      repeat (16) @(posedge clk);
      rst_n_i <= 1'b1;

      start_test("reset");
      @(negedge clk);
      check_flag(!hdr_valid_o && !rd_valid_o && !done_o, "outputs active after reset");
      check_flag(req_ready_o, "req_ready_o low after reset");
      end_test();

      start_test("header");
      repeat (5) write_frame(2 + int'($urandom_range(18)));
      end_test();

      start_test("readback");
      write_frame(256 - int'(model_ptr));   // fills the buffer so the pointer wraps back to 0
      request(8'd0, 40);
      collect(8'd0, 40);
      request(8'd240, 40);   // wraps past 255
      collect(8'd240, 40);
      end_test();

      start_test("write_priority");
      fork
         begin
            repeat (3)
            begin
               write_frame(10 + int'($urandom_range(20)));
               repeat (int'($urandom_range(3))) @(posedge clk);
            end
         end
         begin
            request(8'd128, 60);   // far from the region being written
            collect(8'd128, 60);
         end
      join
      end_test();

      start_test("busy_request");
      acc = accept_count;
      request(8'd200, 30);
      @(posedge clk);
      req_valid_i <= 1'b1;   // second request held during the transfer
      req_start_i <= 8'd10;
      req_len_i   <= 8'd8;
      collect(8'd200, 30);
      check_flag(accept_count == acc + 1, "second request accepted before done");
      check_flag(req_ready_o, "req_ready_o low after done");
      @(posedge clk);
      req_valid_i <= 1'b0;
      collect(8'd10, 8);
      end_test();

      $display("tests run: %0d, errors: %0d", test_count, error_count);
      if (error_count == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial
   begin
      repeat (LIMIT_CYCLES) @(posedge clk);
      $display("watchdog expired in test %s, DUT stopped responding", test_name);
      $display("Result: FAILED");
      $finish;
   end

endmodule

//--- build.f
iba_pkg.sv
dpq_pkg.sv
ram_if.sv
frame_ram.sv
frame_writer.sv
read_sequencer.sv
iba_ctrl.sv
iba_buffer_top.sv
tb_iba_buffer.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module tb_iba_buffer \
   -Mdir obj_dir -o tb_sim > build.log 2>&1 \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { cat build.log; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
